//--- src/fp_consts.svh
// Format widths, bias, special result words and shift limits for the binary32 pipeline; include where needed
`ifndef FP_CONSTS_SVH
`define FP_CONSTS_SVH

// IEEE 754 binary32 field widths
`define FP_EXP_WIDTH 8
`define FP_SIG_WIDTH 23
`define FP_BIAS 127

// Result words for invalid operations
`define FP_CANON_NAN 32'h7fc00000
`define FP_FTOI_INVALID 32'h80000000

// Alignment of the smaller addend
`define FP_ALIGN_MAX 27
`define FP_GUARD_BITS 3

// Thread number width of the issuing core
`define THREAD_IDX_WIDTH 2

`endif

//--- src/fp_pkg.sv
// Shared types for the floating point pipeline; imported by every stage and the top level
`default_nettype none

`include "fp_consts.svh"

package fp_pkg;

	typedef enum logic [1:0]
	{
		FP_ADD,
		FP_SUB,
		FP_MUL,
		FP_FTOI
	} fp_op_t;

	typedef struct packed
	{
		logic sign;
		logic [`FP_EXP_WIDTH - 1:0] exponent;
		logic [`FP_SIG_WIDTH - 1:0] significand;
	} float32_t;

	// One data word, read as a float or as a two's complement integer
	typedef union packed
	{
		float32_t fp;
		logic [31:0] raw;
	} fp_word_u;

	typedef logic [`THREAD_IDX_WIDTH - 1:0] thread_idx_t;

	typedef struct packed
	{
		logic valid;
		fp_op_t op;
		thread_idx_t thread;
		fp_word_u operand1;
		fp_word_u operand2;
	} fp_issue_t;

	// Stage 1 to stage 2
	typedef struct packed
	{
		logic valid;
		fp_op_t op;
		thread_idx_t thread;
		logic result_is_nan;
		logic result_is_inf;
		logic [`FP_SIG_WIDTH:0] significand_le;
		logic [`FP_SIG_WIDTH:0] significand_se;
		logic [5:0] align_shift;
		logic [4:0] ftoi_lshift;
		logic [`FP_EXP_WIDTH - 1:0] add_exponent;
		logic logical_subtract;
		logic add_sign;
		logic signed [9:0] mul_exponent;
		logic mul_sign;
	} fp_fx1_t;

	// Stage 2 to stage 3, leading one expected at bit 46 of the magnitude
	typedef struct packed
	{
		logic valid;
		fp_op_t op;
		thread_idx_t thread;
		logic nan;
		logic inf;
		logic [2 * `FP_SIG_WIDTH + 1:0] magnitude;
		logic signed [9:0] exponent;
		logic sign;
	} fp_fx2_t;

	typedef struct packed
	{
		logic valid;
		thread_idx_t thread;
		fp_word_u value;
	} fp_result_t;

endpackage

`default_nettype wire

//--- src/fp_align_stage.sv
// Stage 1 of the FP pipeline: classifies and sorts operands, computes shifts and drops rolled-back ops
`timescale 1ns/1ps
`default_nettype none

`include "fp_consts.svh"

module fp_align_stage(
	input logic clk,
	input logic reset,
	input fp_pkg::fp_issue_t issue,
	input logic rollback_en,
	input fp_pkg::thread_idx_t rollback_thread,
	output fp_pkg::fp_fx1_t fx1);

	import fp_pkg::*;

	// Exponent at which the significand LSB has weight one
	localparam logic [`FP_EXP_WIDTH - 1:0] FTOI_POINT_EXP = 8'(`FP_BIAS + `FP_SIG_WIDTH);
	// Smallest exponent that no longer fits a signed 32-bit integer
	localparam logic [`FP_EXP_WIDTH - 1:0] FTOI_LIMIT_EXP = 8'(`FP_BIAS + 31);
	localparam logic [`FP_EXP_WIDTH - 1:0] EXP_MAX = '1;

	float32_t fop1;
	float32_t fop2;
	logic [`FP_SIG_WIDTH:0] full_sig1;
	logic [`FP_SIG_WIDTH:0] full_sig2;
	logic fop1_is_zero;
	logic fop2_is_zero;
	logic fop1_is_inf;
	logic fop2_is_inf;
	logic fop1_is_nan;
	logic fop2_is_nan;
	logic is_sub;
	logic is_mul;
	logic is_ftoi;
	logic op1_is_larger;
	logic [`FP_EXP_WIDTH - 1:0] exp_difference;
	logic logical_subtract;
	logic exact_cancel;
	logic result_is_nan;
	logic [5:0] ftoi_rshift;
	logic [4:0] ftoi_lshift;
	logic signed [9:0] mul_exponent;
	fp_fx1_t fx1_nxt;

	assign fop1 = issue.operand1.fp;
	assign fop2 = issue.operand2.fp;
	assign is_sub = issue.op == FP_SUB;
	assign is_mul = issue.op == FP_MUL;
	assign is_ftoi = issue.op == FP_FTOI;

	// Subnormals count as zero, so no hidden bit and no fraction
	assign fop1_is_zero = fop1.exponent == '0;
	assign fop2_is_zero = fop2.exponent == '0;
	assign full_sig1 = fop1_is_zero ? '0 : {1'b1, fop1.significand};
	assign full_sig2 = fop2_is_zero ? '0 : {1'b1, fop2.significand};

	assign fop1_is_inf = fop1.exponent == EXP_MAX && fop1.significand == '0;
	assign fop2_is_inf = fop2.exponent == EXP_MAX && fop2.significand == '0;
	assign fop1_is_nan = fop1.exponent == EXP_MAX && fop1.significand != '0;
	assign fop2_is_nan = fop2.exponent == EXP_MAX && fop2.significand != '0;

	// Effective operation after signs and opcode
	assign logical_subtract = fop1.sign ^ fop2.sign ^ is_sub;

	// Equal magnitudes cancel to +0
	assign exact_cancel = !is_mul && !is_ftoi && logical_subtract
		&& fop1.exponent == fop2.exponent && full_sig1 == full_sig2;

	// Ties keep operand1 in the larger lane
	assign op1_is_larger = fop1.exponent > fop2.exponent
		|| (fop1.exponent == fop2.exponent && full_sig1 >= full_sig2);
	assign exp_difference = op1_is_larger ? fop1.exponent - fop2.exponent
		: fop2.exponent - fop1.exponent;

	// Biased product exponent, sign bit catches underflow
	assign mul_exponent = 10'(fop1.exponent) + 10'(fop2.exponent) - 10'(`FP_BIAS);

	always_comb
	begin
		if (is_mul)
			result_is_nan = fop1_is_nan || fop2_is_nan
				|| (fop1_is_inf && fop2_is_zero) || (fop2_is_inf && fop1_is_zero);
		else if (is_ftoi)
			result_is_nan = fop2_is_nan || fop2_is_inf || fop2.exponent >= FTOI_LIMIT_EXP;
		else
			result_is_nan = fop1_is_nan || fop2_is_nan
				|| (fop1_is_inf && fop2_is_inf && logical_subtract);
	end

	// Float-to-int source is operand2, shifted so the binary point sits at bit 0
	always_comb
	begin
		if (fop2.exponent < 8'(`FP_BIAS))
		begin
			// Below one, shift every bit out
			ftoi_rshift = 6'(`FP_SIG_WIDTH + 1);
			ftoi_lshift = '0;
		end
		else if (fop2.exponent <= FTOI_POINT_EXP)
		begin
			ftoi_rshift = 6'(FTOI_POINT_EXP - fop2.exponent);
			ftoi_lshift = '0;
		end
		else
		begin
			ftoi_rshift = '0;
			ftoi_lshift = 5'(fop2.exponent - FTOI_POINT_EXP);
		end
	end

	always_comb
	begin
		fx1_nxt.valid = issue.valid && !(rollback_en && rollback_thread == issue.thread);
		fx1_nxt.op = issue.op;
		fx1_nxt.thread = issue.thread;
		fx1_nxt.result_is_nan = result_is_nan;
		fx1_nxt.result_is_inf = !is_ftoi && !result_is_nan && (fop1_is_inf || fop2_is_inf);
		fx1_nxt.ftoi_lshift = ftoi_lshift;
		fx1_nxt.logical_subtract = logical_subtract;
		fx1_nxt.mul_exponent = mul_exponent;
		fx1_nxt.mul_sign = fop1.sign ^ fop2.sign;

		if (is_ftoi)
		begin
			// Integer conversion runs down the smaller lane alone
			fx1_nxt.significand_le = '0;
			fx1_nxt.significand_se = full_sig2;
			fx1_nxt.add_exponent = fop2.exponent;
			fx1_nxt.add_sign = fop2.sign;
			fx1_nxt.align_shift = ftoi_rshift;
		end
		else
		begin
			if (op1_is_larger)
			begin
				fx1_nxt.significand_le = full_sig1;
				fx1_nxt.significand_se = full_sig2;
				fx1_nxt.add_exponent = fop1.exponent;
				fx1_nxt.add_sign = fop1.sign;
			end
			else
			begin
				fx1_nxt.significand_le = full_sig2;
				fx1_nxt.significand_se = full_sig1;
				fx1_nxt.add_exponent = fop2.exponent;
				fx1_nxt.add_sign = fop2.sign ^ is_sub;
			end

			// Past 27 the guard bits are gone too
			fx1_nxt.align_shift = exp_difference > 8'(`FP_ALIGN_MAX) ? 6'(`FP_ALIGN_MAX)
				: 6'(exp_difference);

			if (exact_cancel)
				fx1_nxt.add_sign = 1'b0;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			fx1.valid <= 1'b0;
		else
			fx1 <= fx1_nxt;
	end

	// Shift range seen by stage 2
	assert property (@(posedge clk) disable iff (reset)
		fx1.valid |-> fx1.align_shift <= 6'(`FP_ALIGN_MAX));

	assert property (@(posedge clk) disable iff (reset) !$isunknown(fx1.valid));

endmodule

`default_nettype wire

//--- src/fp_combine_stage.sv
// Stage 2 of the FP pipeline: aligns and adds significands, multiplies, or shifts float-to-int values
`timescale 1ns/1ps
`default_nettype none

`include "fp_consts.svh"

module fp_combine_stage(
	input logic clk,
	input logic reset,
	input fp_pkg::fp_fx1_t fx1,
	output fp_pkg::fp_fx2_t fx2);

	import fp_pkg::*;

	// Hidden bit, fraction and guard bits
	localparam int ADD_WIDTH = `FP_SIG_WIDTH + 1 + `FP_GUARD_BITS;
	localparam int MAG_WIDTH = 2 * (`FP_SIG_WIDTH + 1);
	// Puts the sum's hidden bit where the product's sits
	localparam int ADD_PAD = MAG_WIDTH - ADD_WIDTH - 1;

	logic [ADD_WIDTH - 1:0] le_ext;
	logic [ADD_WIDTH - 1:0] se_aligned;
	logic [ADD_WIDTH:0] add_sum;
	logic [MAG_WIDTH - 1:0] product;
	logic [MAG_WIDTH - 1:0] ftoi_mag;
	fp_fx2_t fx2_nxt;

	assign le_ext = {fx1.significand_le, {`FP_GUARD_BITS{1'b0}}};

	// Bits below the guard bits are lost here
	assign se_aligned = {fx1.significand_se, {`FP_GUARD_BITS{1'b0}}} >> fx1.align_shift;

	// Larger lane always wins, so the difference never goes negative
	assign add_sum = fx1.logical_subtract ? {1'b0, le_ext} - {1'b0, se_aligned}
		: {1'b0, le_ext} + {1'b0, se_aligned};

	assign product = MAG_WIDTH'(fx1.significand_le) * MAG_WIDTH'(fx1.significand_se);

	// Drop the fraction, then scale up large values
	assign ftoi_mag = (MAG_WIDTH'(fx1.significand_se) >> fx1.align_shift) << fx1.ftoi_lshift;

	always_comb
	begin
		fx2_nxt.valid = fx1.valid;
		fx2_nxt.op = fx1.op;
		fx2_nxt.thread = fx1.thread;
		fx2_nxt.nan = fx1.result_is_nan;
		fx2_nxt.inf = fx1.result_is_inf;

		case (fx1.op)
			FP_MUL:
			begin
				fx2_nxt.magnitude = product;
				fx2_nxt.exponent = fx1.mul_exponent;
				fx2_nxt.sign = fx1.mul_sign;
			end

			FP_FTOI:
			begin
				// Integer sits in the low word, exponent unused
				fx2_nxt.magnitude = ftoi_mag;
				fx2_nxt.exponent = '0;
				fx2_nxt.sign = fx1.add_sign;
			end

			default:
			begin
				fx2_nxt.magnitude = {add_sum, {ADD_PAD{1'b0}}};
				fx2_nxt.exponent = 10'(fx1.add_exponent);
				fx2_nxt.sign = fx1.add_sign;
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			fx2.valid <= 1'b0;
		else
			fx2 <= fx2_nxt;
	end

endmodule

`default_nettype wire

//--- src/fp_normalize_stage.sv
// Stage 3 of the FP pipeline: normalizes, handles special cases and packs the result word
`timescale 1ns/1ps
`default_nettype none

`include "fp_consts.svh"

module fp_normalize_stage(
	input logic clk,
	input logic reset,
	input fp_pkg::fp_fx2_t fx2,
	output fp_pkg::fp_result_t result);

	import fp_pkg::*;

	localparam int MAG_WIDTH = 2 * (`FP_SIG_WIDTH + 1);
	localparam logic [`FP_EXP_WIDTH - 1:0] EXP_MAX = '1;

	logic [5:0] lz_count;
	logic [MAG_WIDTH - 1:0] normalized;
	logic signed [9:0] norm_exponent;
	logic exp_overflow;
	logic exp_underflow;
	logic mag_is_zero;
	logic [31:0] ftoi_value;
	fp_word_u word_nxt;

	// Leading zero count, full width when the magnitude is zero
	always_comb
	begin
		lz_count = 6'(MAG_WIDTH);
		for (int i = 0; i < MAG_WIDTH; i++)
		begin
			if (fx2.magnitude[i])
				lz_count = 6'(MAG_WIDTH - 1 - i);
		end
	end

	// Leading one moves to the top bit
	assign normalized = fx2.magnitude << lz_count;

	// Exponent is referenced to bit 46, one below the top
	assign norm_exponent = fx2.exponent + 10'sd1 - $signed({4'b0, lz_count});

	assign exp_overflow = norm_exponent >= $signed(10'(EXP_MAX));
	assign exp_underflow = norm_exponent <= 10'sd0;
	assign mag_is_zero = fx2.magnitude == '0;

	// Two's complement for negative integers
	assign ftoi_value = fx2.sign ? -fx2.magnitude[31:0] : fx2.magnitude[31:0];

	always_comb
	begin
		word_nxt.raw = '0;

		if (fx2.op == FP_FTOI)
			word_nxt.raw = fx2.nan ? `FP_FTOI_INVALID : ftoi_value;
		else if (fx2.nan)
			word_nxt.raw = `FP_CANON_NAN;
		else
		begin
			word_nxt.fp.sign = fx2.sign;
			if (fx2.inf)
				word_nxt.fp.exponent = EXP_MAX;
			else if (mag_is_zero || exp_underflow)
			begin
				// Signed zero, already cleared
			end
			else if (exp_overflow)
				word_nxt.fp.exponent = EXP_MAX;
			else
			begin
				// Truncate everything below the kept fraction
				word_nxt.fp.exponent = norm_exponent[`FP_EXP_WIDTH - 1:0];
				word_nxt.fp.significand = normalized[MAG_WIDTH - 2 -: `FP_SIG_WIDTH];
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			result.valid <= 1'b0;
		else
		begin
			result.valid <= fx2.valid;
			result.thread <= fx2.thread;
			result.value <= word_nxt;
		end
	end

	// A finite nonzero float result came from a properly normalized magnitude
	assert property (@(posedge clk) disable iff (reset)
		result.valid && $past(fx2.op) != FP_FTOI && result.value.fp.exponent != '0
			&& result.value.fp.exponent != EXP_MAX |-> $past(normalized[MAG_WIDTH - 1]));

endmodule

`default_nettype wire

//--- src/fp_pipe.sv
// Top level of the three-stage FP pipeline; issue in, result out three cycles later
`timescale 1ns/1ps
`default_nettype none

module fp_pipe(
	input logic clk,
	input logic reset,
	input fp_pkg::fp_issue_t issue,
	input logic rollback_en,
	input fp_pkg::thread_idx_t rollback_thread,
	output fp_pkg::fp_result_t result);

	import fp_pkg::*;

	fp_fx1_t fx1;
	fp_fx2_t fx2;

	// Classify, sort and squash
	fp_align_stage fp_align_stage_inst(
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.fx1(fx1));

	// Add, multiply or integer shift
	fp_combine_stage fp_combine_stage_inst(
		.clk(clk),
		.reset(reset),
		.fx1(fx1),
		.fx2(fx2));

	// Normalize and pack
	fp_normalize_stage fp_normalize_stage_inst(
		.clk(clk),
		.reset(reset),
		.fx2(fx2),
		.result(result));

endmodule

`default_nettype wire

//--- test/fp_clock_gen.sv
// Testbench clock and reset source; 100 ns clock, reset held for the first five cycles
`timescale 1ns/1ps
`default_nettype none

module fp_clock_gen(
	output logic clk,
	output logic reset);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Released on a falling edge, away from the sampling edge
	initial
	begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- test/fp_pipe_tb.sv
// Testbench for the FP pipeline; issues directed and random operations and checks each result
`timescale 1ns/1ps
`default_nettype none

`include "fp_consts.svh"

module fp_pipe_tb;

	import fp_pkg::*;

	// One outstanding result and the edge it is due on
	typedef struct packed
	{
		int due;
		logic [31:0] value;
		thread_idx_t thread;
	} expect_t;

	logic clk;
	logic reset;
	fp_issue_t issue;
	logic rollback_en;
	thread_idx_t rollback_thread;
	fp_result_t result;

	expect_t expect_q[$];
	int cycle = 0;
	int reset_edges = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int seed = 54;
	logic timed_out = 1'b0;

	fp_clock_gen fp_clock_gen_inst(
		.clk(clk),
		.reset(reset));

	fp_pipe fp_pipe_inst(
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.result(result));

	function automatic logic is_nan(input logic [31:0] x);
		return x[30:23] == 8'hff && x[22:0] != 23'd0;
	endfunction

	function automatic logic is_inf(input logic [31:0] x);
		return x[30:23] == 8'hff && x[22:0] == 23'd0;
	endfunction

	// Add or subtract with three guard bits, truncating
	function automatic logic [31:0] expected_sum(input logic [31:0] a, input logic [31:0] b,
		input logic subtract);
		logic sa;
		logic sb;
		logic sbig;
		logic [7:0] ebig;
		logic [7:0] esmall;
		logic [7:0] diff;
		logic [23:0] ma;
		logic [23:0] mb;
		logic [23:0] mbig;
		logic [23:0] msmall;
		logic [26:0] small_ext;
		logic [27:0] sum;
		logic [27:0] norm;
		int lead;
		int exp_out;
		sa = a[31];
		sb = b[31] ^ subtract;
		// Subnormals lose their fraction
		ma = (a[30:23] == 8'd0) ? 24'd0 : {1'b1, a[22:0]};
		mb = (b[30:23] == 8'd0) ? 24'd0 : {1'b1, b[22:0]};
		if (is_nan(a) || is_nan(b) || (is_inf(a) && is_inf(b) && sa != sb))
			return `FP_CANON_NAN;
		if (is_inf(a))
			return {sa, 8'hff, 23'd0};
		if (is_inf(b))
			return {sb, 8'hff, 23'd0};
		// Equal magnitudes leave a on top
		if (a[30:23] > b[30:23] || (a[30:23] == b[30:23] && ma >= mb))
		begin
			sbig = sa;
			ebig = a[30:23];
			esmall = b[30:23];
			mbig = ma;
			msmall = mb;
		end
		else
		begin
			sbig = sb;
			ebig = b[30:23];
			esmall = a[30:23];
			mbig = mb;
			msmall = ma;
		end
		diff = ebig - esmall;
		if (diff > 8'd27)
			diff = 8'd27;
		small_ext = {msmall, 3'b000} >> diff;
		if (sa != sb)
			sum = {1'b0, mbig, 3'b000} - {1'b0, small_ext};
		else
			sum = {1'b0, mbig, 3'b000} + {1'b0, small_ext};
		// Cancellation is +0, a sum of zeros keeps its sign
		if (sum == 28'd0)
			return {(sa != sb) ? 1'b0 : sbig, 31'd0};
		lead = 0;
		for (int i = 0; i < 28; i++)
		begin
			if (sum[i])
				lead = i;
		end
		exp_out = int'(ebig) + lead - 26;
		if (exp_out >= 255)
			return {sbig, 8'hff, 23'd0};
		if (exp_out <= 0)
			return {sbig, 31'd0};
		norm = sum << (27 - lead);
		return {sbig, 8'(exp_out), norm[26:4]};
	endfunction

	function automatic logic [31:0] expected_product(input logic [31:0] a, input logic [31:0] b);
		logic sign;
		logic a_zero;
		logic b_zero;
		logic [47:0] prod;
		logic [22:0] frac;
		int exp_out;
		sign = a[31] ^ b[31];
		a_zero = a[30:23] == 8'd0;
		b_zero = b[30:23] == 8'd0;
		if (is_nan(a) || is_nan(b) || (is_inf(a) && b_zero) || (is_inf(b) && a_zero))
			return `FP_CANON_NAN;
		if (is_inf(a) || is_inf(b))
			return {sign, 8'hff, 23'd0};
		if (a_zero || b_zero)
			return {sign, 31'd0};
		prod = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
		exp_out = int'(a[30:23]) + int'(b[30:23]) - `FP_BIAS;
		if (prod[47])
		begin
			exp_out = exp_out + 1;
			frac = prod[46:24];
		end
		else
			frac = prod[45:23];
		if (exp_out >= 255)
			return {sign, 8'hff, 23'd0};
		if (exp_out <= 0)
			return {sign, 31'd0};
		return {sign, 8'(exp_out), frac};
	endfunction

	// Truncation toward zero of the second operand
	function automatic logic [31:0] expected_int(input logic [31:0] b);
		logic [31:0] mag;
		if (b[30:23] >= 8'd158)
			return `FP_FTOI_INVALID;
		if (b[30:23] < 8'd127)
			return 32'd0;
		mag = 32'({1'b1, b[22:0]});
		if (b[30:23] <= 8'd150)
			mag = mag >> (8'd150 - b[30:23]);
		else
			mag = mag << (b[30:23] - 8'd150);
		return b[31] ? -mag : mag;
	endfunction

	function automatic logic [31:0] model_fp(input fp_op_t op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			FP_ADD: return expected_sum(a, b, 1'b0);
			FP_SUB: return expected_sum(a, b, 1'b1);
			FP_MUL: return expected_product(a, b);
			default: return expected_int(b);
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks = checks + 1;
		if (actual !== expected)
		begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, name, actual, expected);
			errors = errors + 1;
		end
	endtask

	always @(posedge clk)
	begin
		expect_t entry;
		cycle = cycle + 1;
		if (reset)
		begin
			// First edge may come before the reset has settled
			if (reset_edges > 0)
				check_value("result.valid", 32'(result.valid), 32'd0);
			reset_edges = reset_edges + 1;
		end
		else
		begin
			if (expect_q.size() > 0 && expect_q[0].due == cycle)
			begin
				entry = expect_q.pop_front();
				if (result.valid !== 1'b1)
				begin
					$display("Missing result at %0t: thread %0d expected %h, result.valid low",
						$time, entry.thread, entry.value);
					errors = errors + 1;
				end
				else
				begin
					check_value("result.value", result.value.raw, entry.value);
					check_value("result.thread", 32'(result.thread), 32'(entry.thread));
				end
			end
			else if (result.valid !== 1'b0)
			begin
				$display("Unexpected result at %0t: value %h on thread %0d with none due",
					$time, result.value.raw, result.thread);
				errors = errors + 1;
			end
			// Operation sampled at this edge, squashed if its thread rolls back now
			if (issue.valid && !(rollback_en && rollback_thread == issue.thread))
			begin
				entry.due = cycle + 3;
				entry.value = model_fp(issue.op, issue.operand1.raw, issue.operand2.raw);
				entry.thread = issue.thread;
				expect_q.push_back(entry);
			end
		end
	end

	// Mostly near one, so sums, products and conversions stay in range
	function automatic logic [31:0] random_operand();
		logic [31:0] bits;
		logic [31:0] pick;
		bits = $random(seed);
		pick = $random(seed);
		case (pick[1:0])
			2'd0: return bits;
			2'd1: return {bits[31], 8'd112 + 8'(pick[6:2]), bits[22:0]};
			default: return {bits[31], 8'd127 + 8'(pick[6:2]), bits[22:0]};
		endcase
	endfunction

	task automatic issue_op(input fp_op_t op, input logic [31:0] a, input logic [31:0] b,
		input thread_idx_t thread);
		@(posedge clk);
		issue.valid <= 1'b1;
		issue.op <= op;
		issue.thread <= thread;
		issue.operand1.raw <= a;
		issue.operand2.raw <= b;
		rollback_en <= 1'b0;
	endtask

	task automatic go_idle();
		@(posedge clk);
		issue.valid <= 1'b0;
		rollback_en <= 1'b0;
	endtask

	task automatic wait_for_results();
		int waited;
		waited = 0;
		while (expect_q.size() != 0 && waited < 50)
		begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (expect_q.size() != 0)
		begin
			$display("Timeout at %0t: %0d results never arrived", $time, expect_q.size());
			timed_out = 1'b1;
		end
	endtask

	// Drain, let stray results show up, then report
	task automatic close_test(input string name, input int start);
		go_idle();
		wait_for_results();
		repeat (4) @(negedge clk);
		tests = tests + 1;
		$display("Test %0d %s: %s, %0d errors", tests, name,
			(errors == start) ? "ok" : "FAILED", errors - start);
	endtask

	task automatic reset_check();
		int start;
		int waited;
		start = errors;
		waited = 0;
		while (reset !== 1'b0 && waited < 20)
		begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (reset !== 1'b0)
		begin
			$display("Timeout at %0t: reset was never released", $time);
			timed_out = 1'b1;
		end
		close_test("reset", start);
	endtask

	task automatic add_sub_cases();
		int start;
		start = errors;
		issue_op(FP_ADD, 32'h3f800000, 32'h40000000, 2'd0);
		issue_op(FP_ADD, 32'hbfc00000, 32'hc0100000, 2'd1);
		issue_op(FP_SUB, 32'h40a00000, 32'h40a00000, 2'd2);
		issue_op(FP_ADD, 32'h40400000, 32'hc0400000, 2'd3);
		issue_op(FP_ADD, 32'hc0000000, 32'h40000000, 2'd0);
		issue_op(FP_SUB, 32'h7f800000, 32'h7f800000, 2'd1);
		issue_op(FP_ADD, 32'h00000001, 32'h3f800000, 2'd2);
		issue_op(FP_SUB, 32'h00400000, 32'h3f800000, 2'd3);
		issue_op(FP_ADD, 32'h00400000, 32'h80400000, 2'd0);
		// Tiny addend falls below the guard bits
		issue_op(FP_ADD, 32'h3f800000, 32'h33333333, 2'd1);
		issue_op(FP_SUB, 32'h3f800000, 32'h3f7fffff, 2'd2);
		issue_op(FP_ADD, 32'h7f7fffff, 32'h7f7fffff, 2'd3);
		issue_op(FP_ADD, 32'hff800000, 32'h3f800000, 2'd0);
		close_test("add and subtract", start);
	endtask

	task automatic multiply_cases();
		int start;
		start = errors;
		issue_op(FP_MUL, 32'h3fc00000, 32'h40000000, 2'd0);
		issue_op(FP_MUL, 32'hc0400000, 32'h40800000, 2'd1);
		issue_op(FP_MUL, 32'h7f000000, 32'h40000000, 2'd2);
		issue_op(FP_MUL, 32'hff000000, 32'h40800000, 2'd3);
		issue_op(FP_MUL, 32'h00800000, 32'h00800000, 2'd0);
		issue_op(FP_MUL, 32'h80800000, 32'h00800000, 2'd1);
		issue_op(FP_MUL, 32'h7f800000, 32'h00000000, 2'd2);
		issue_op(FP_MUL, 32'h7fc12345, 32'h3f800000, 2'd3);
		issue_op(FP_MUL, 32'hff800000, 32'h40000000, 2'd0);
		issue_op(FP_MUL, 32'h3f800000, 32'h00000005, 2'd1);
		close_test("multiply", start);
	endtask

	// Source is operand2, operand1 is ignored
	task automatic convert_cases();
		int start;
		start = errors;
		issue_op(FP_FTOI, 32'h12345678, 32'h3fc00000, 2'd0);
		issue_op(FP_FTOI, 32'h12345678, 32'hc0200000, 2'd1);
		issue_op(FP_FTOI, 32'h12345678, 32'h3f000000, 2'd2);
		issue_op(FP_FTOI, 32'h12345678, 32'hbf7fffff, 2'd3);
		issue_op(FP_FTOI, 32'h12345678, 32'h4f000000, 2'd0);
		issue_op(FP_FTOI, 32'h12345678, 32'hcf000000, 2'd1);
		issue_op(FP_FTOI, 32'h12345678, 32'h4effffff, 2'd2);
		issue_op(FP_FTOI, 32'h12345678, 32'h7f800000, 2'd3);
		issue_op(FP_FTOI, 32'h12345678, 32'h7fc00000, 2'd0);
		issue_op(FP_FTOI, 32'h12345678, 32'h4b800001, 2'd1);
		issue_op(FP_FTOI, 32'h12345678, 32'h80000000, 2'd2);
		close_test("float to int", start);
	endtask

	task automatic random_stream();
		int start;
		logic [31:0] pick;
		start = errors;
		for (int i = 0; i < 200; i++)
		begin
			pick = $random(seed);
			issue_op(fp_op_t'(pick[1:0]), random_operand(), random_operand(),
				thread_idx_t'(pick[3:2]));
		end
		close_test("random back-to-back stream", start);
	endtask

	task automatic rollback_stream();
		int start;
		logic [31:0] pick;
		start = errors;
		for (int i = 0; i < 48; i++)
		begin
			pick = $random(seed);
			issue_op(fp_op_t'(pick[1:0]), random_operand(), random_operand(),
				thread_idx_t'(i % 4));
			// Own thread every sixth op, a neighbour three ops later
			if (i % 6 == 0)
			begin
				rollback_en <= 1'b1;
				rollback_thread <= thread_idx_t'(i % 4);
			end
			else if (i % 6 == 3)
			begin
				rollback_en <= 1'b1;
				rollback_thread <= thread_idx_t'((i + 1) % 4);
			end
		end
		close_test("rollback", start);
	endtask

	initial
	begin
		issue <= '0;
		rollback_en <= 1'b0;
		rollback_thread <= '0;
		reset_check();
		if (!timed_out)
			add_sub_cases();
		if (!timed_out)
			multiply_cases();
		if (!timed_out)
			convert_cases();
		if (!timed_out)
			random_stream();
		if (!timed_out)
			rollback_stream();
		$display("Summary: %0d tests, %0d checks, %0d errors%s", tests, checks, errors,
			timed_out ? ", stopped by a timeout" : "");
		if (errors == 0 && !timed_out)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- fp_pipe.f
+incdir+src
src/fp_pkg.sv
src/fp_align_stage.sv
src/fp_combine_stage.sv
src/fp_normalize_stage.sv
src/fp_pipe.sv
test/fp_clock_gen.sv
test/fp_pipe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the FP pipeline testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module fp_pipe_tb \
	-Mdir "$build_dir" \
	-f fp_pipe.f

"./$build_dir/Vfp_pipe_tb" | tee "$log_file"

if grep -qF "*** TEST FAILED ***" "$log_file"; then
	echo "Simulation failed, see $log_file"
	exit 1
fi
echo "Simulation passed"
